/* design/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// data and address width
`define MEM_XLEN 64

// bytes per doubleword
`define MEM_BYTES (`MEM_XLEN / 8)

// first doubleword of the data memory
`define MEM_BASE 64'h8000_0000

// number of doublewords is 2**MEM_DEPTH_LOG2
`define MEM_DEPTH_LOG2 10

`define MEM_DEPTH (1 << `MEM_DEPTH_LOG2)

`endif

/* design/mem_op_pkg.sv */
package mem_op_pkg;

  // memory operation carried by the instruction
  typedef enum logic [3:0] {
    MOP_NONE = 4'd0,
    MOP_LB   = 4'd1,
    MOP_LBU  = 4'd2,
    MOP_LH   = 4'd3,
    MOP_LHU  = 4'd4,
    MOP_LW   = 4'd5,
    MOP_LWU  = 4'd6,
    MOP_LD   = 4'd7,
    MOP_SB   = 4'd8,
    MOP_SH   = 4'd9,
    MOP_SW   = 4'd10,
    MOP_SD   = 4'd11
  } mem_op_e;

  // access width
  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2,
    SZ_D = 2'd3
  } acc_size_e;

  function automatic logic is_load(mem_op_e op);
    return op inside {MOP_LB, MOP_LBU, MOP_LH, MOP_LHU, MOP_LW, MOP_LWU, MOP_LD};
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op inside {MOP_SB, MOP_SH, MOP_SW, MOP_SD};
  endfunction

  // none falls back to a full doubleword
  function automatic acc_size_e op_size(mem_op_e op);
    case (op)
      MOP_LB, MOP_LBU, MOP_SB: return SZ_B;
      MOP_LH, MOP_LHU, MOP_SH: return SZ_H;
      MOP_LW, MOP_LWU, MOP_SW: return SZ_W;
      default:                 return SZ_D;
    endcase
  endfunction

endpackage

/* design/pipe_pkg.sv */
`include "mem_params.svh"

package pipe_pkg;

  import mem_op_pkg::*;

  // execute to memory bundle
  typedef struct packed {
    mem_op_e              op;
    // alu result, doubles as the address
    logic [`MEM_XLEN-1:0] ex_data;
    // raw rs2 value
    logic [`MEM_XLEN-1:0] store_data;
    logic                 rd_en;
    logic [4:0]           rd_addr;
    logic [31:0]          inst;
    logic [`MEM_XLEN-1:0] pc;
  } ex_mem_t;

  // memory to writeback bundle
  typedef struct packed {
    logic [`MEM_XLEN-1:0] result;
    logic                 rd_en;
    logic [4:0]           rd_addr;
    logic [31:0]          inst;
    logic [`MEM_XLEN-1:0] pc;
  } mem_wb_t;

endpackage

/* design/store_format.sv */
`include "mem_params.svh"

module store_format import mem_op_pkg::*; (
  input  mem_op_e                 op,
  input  logic [2:0]              addr_lo,
  input  logic [`MEM_XLEN-1:0]    store_data,
  output logic [`MEM_XLEN-1:0]    wdata,
  output logic [`MEM_BYTES-1:0]   wmask
);

  acc_size_e              size;
  logic [`MEM_BYTES-1:0]  lane_mask;

  assign size = op_size(op);

  // replicate the low bytes across every lane, the mask picks the one written
  always_comb begin
    case (size)
      SZ_B: begin
        wdata     = {8{store_data[7:0]}};
        lane_mask = 8'b0000_0001 << addr_lo;
      end
      SZ_H: begin
        wdata     = {4{store_data[15:0]}};
        lane_mask = 8'b0000_0011 << {addr_lo[2:1], 1'b0};
      end
      SZ_W: begin
        wdata     = {2{store_data[31:0]}};
        lane_mask = 8'b0000_1111 << {addr_lo[2], 2'b00};
      end
      default: begin
        wdata     = store_data;
        lane_mask = 8'b1111_1111;
      end
    endcase
  end

  // no byte enables unless this is a store
  assign wmask = is_store(op) ? lane_mask : '0;

endmodule

/* design/data_ram.sv */
`include "mem_params.svh"

module data_ram (
  input  logic                        clk,
  input  logic                        en,
  input  logic                        wen,
  input  logic [`MEM_DEPTH_LOG2-1:0]  idx,
  input  logic [`MEM_XLEN-1:0]        wdata,
  input  logic [`MEM_BYTES-1:0]       wmask,
  output logic [`MEM_XLEN-1:0]        rdata
);

  // doubleword storage
  logic [`MEM_XLEN-1:0] mem [`MEM_DEPTH];

  // byte-masked write on the edge
  always_ff @(posedge clk) begin
    if (en && wen) begin
      for (int b = 0; b < `MEM_BYTES; b++) begin
        if (wmask[b]) begin
          mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // read is combinational, so a load right after a store sees the new bytes
  assign rdata = mem[idx];

endmodule

/* design/load_format.sv */
`include "mem_params.svh"

module load_format import mem_op_pkg::*; (
  input  mem_op_e               op,
  input  logic [2:0]            addr_lo,
  input  logic [`MEM_XLEN-1:0]  rdata,
  output logic [`MEM_XLEN-1:0]  load_data
);

  acc_size_e              size;
  logic                   sign_ext;
  logic [7:0]             lane_b;
  logic [15:0]            lane_h;
  logic [31:0]            lane_w;
  logic [`MEM_XLEN-1:0]   field;

  assign size = op_size(op);

  // only the plain loads sign-extend
  assign sign_ext = (op == MOP_LB) || (op == MOP_LH) || (op == MOP_LW);

  // lane pick, low address bits below the access size are dropped
  always_comb begin
    lane_b = rdata[{addr_lo, 3'b000} +: 8];
    lane_h = rdata[{addr_lo[2:1], 4'b0000} +: 16];
    lane_w = rdata[{addr_lo[2], 5'b00000} +: 32];
  end

  always_comb begin
    case (size)
      SZ_B: begin
        field = {{(`MEM_XLEN-8){sign_ext & lane_b[7]}}, lane_b};
      end
      SZ_H: begin
        field = {{(`MEM_XLEN-16){sign_ext & lane_h[15]}}, lane_h};
      end
      SZ_W: begin
        field = {{(`MEM_XLEN-32){sign_ext & lane_w[31]}}, lane_w};
      end
      default: begin
        field = rdata;
      end
    endcase
  end

  // stores and none give zero
  assign load_data = is_load(op) ? field : '0;

endmodule

/* design/mem_unit.sv */
`include "mem_params.svh"

module mem_unit import mem_op_pkg::*, pipe_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  ex_mem_t ex_in,
  output mem_wb_t wb_out
);

  logic                         ld;
  logic                         st;
  logic [`MEM_XLEN-1:0]         offset;
  logic [2:0]                   addr_lo;
  logic [`MEM_DEPTH_LOG2-1:0]   ram_idx;
  logic                         ram_en;
  logic                         ram_wen;
  logic [`MEM_XLEN-1:0]         ram_wdata;
  logic [`MEM_BYTES-1:0]        ram_wmask;
  logic [`MEM_XLEN-1:0]         ram_rdata;
  logic [`MEM_XLEN-1:0]         load_data;
  mem_wb_t                      wb_next;

  // op decode
  assign ld = is_load(ex_in.op);
  assign st = is_store(ex_in.op);

  // byte offset from the memory base
  assign offset  = ex_in.ex_data - `MEM_BASE;
  assign addr_lo = offset[2:0];

  // doubleword index, wraps at the memory depth
  assign ram_idx = offset[`MEM_DEPTH_LOG2+2:3];

  assign ram_en  = ld || st;
  // writes are dropped while in reset
  assign ram_wen = st && !rst;

  store_format u_store_format (
    .op         (ex_in.op),
    .addr_lo    (addr_lo),
    .store_data (ex_in.store_data),
    .wdata      (ram_wdata),
    .wmask      (ram_wmask)
  );

  data_ram u_data_ram (
    .clk   (clk),
    .en    (ram_en),
    .wen   (ram_wen),
    .idx   (ram_idx),
    .wdata (ram_wdata),
    .wmask (ram_wmask),
    .rdata (ram_rdata)
  );

  load_format u_load_format (
    .op        (ex_in.op),
    .addr_lo   (addr_lo),
    .rdata     (ram_rdata),
    .load_data (load_data)
  );

  // result select and sideband for the stage register
  always_comb begin
    if (ld) begin
      wb_next.result = load_data;
    end else begin
      wb_next.result = ex_in.ex_data;
    end
    wb_next.rd_en   = ex_in.rd_en;
    wb_next.rd_addr = ex_in.rd_addr;
    wb_next.inst    = ex_in.inst;
    wb_next.pc      = ex_in.pc;
  end

  // memory to writeback register
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_out <= '0;
    end else begin
      wb_out <= wb_next;
    end
  end

endmodule

/* bench/mem_unit_sva.sv */
module mem_unit_sva import pipe_pkg::*; (
  input logic    clk,
  input logic    rst,
  input ex_mem_t ex_in,
  input mem_wb_t wb_out
);

  // failure counts, summed by the testbench
  int unsigned reset_fails   = 0;
  int unsigned follow_fails  = 0;
  int unsigned unknown_fails = 0;

  // stage register is zero one edge after reset
  reset_clears: assert property (@(posedge clk) rst |=> (wb_out == '0))
    else begin
      reset_fails++;
      $error("wb_out not zero after a reset edge");
    end

  // sideband lands one cycle later
  sideband_follows: assert property (@(posedge clk) disable iff (rst)
    !rst |=> (wb_out.pc == $past(ex_in.pc)) && (wb_out.rd_addr == $past(ex_in.rd_addr)))
    else begin
      follow_fails++;
      $error("wb_out pc or rd_addr does not match the previous ex_in");
    end

  result_known: assert property (@(posedge clk) wb_out.rd_en |-> !$isunknown(wb_out.result))
    else begin
      unknown_fails++;
      $error("wb_out result unknown while rd_en is set");
    end

endmodule

bind mem_unit mem_unit_sva u_mem_unit_sva (
  .clk    (clk),
  .rst    (rst),
  .ex_in  (ex_in),
  .wb_out (wb_out)
);

/* bench/mem_unit_tb.sv */
`include "mem_params.svh"

module mem_unit_tb import mem_op_pkg::*, pipe_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int RAND_OPS     = 200;
  // bundles sent by all tests together
  localparam int N_BUNDLES    = 8 + 6 + 3 * (8 + 4 + 2) + 1 + 6 * 8 + 4 + RAND_OPS;
  localparam int WATCHDOG     = (N_BUNDLES + RESET_CYCLES + 50) * CLK_PERIOD;

  logic    clk;
  logic    rst;
  ex_mem_t ex_in;
  mem_wb_t wb_out;

  // reference copy of the data memory
  logic [`MEM_XLEN-1:0] ref_mem [`MEM_DEPTH];

  integer      seed;
  int          seq;
  int          errors;
  int          checks;
  int          tests_ok;
  int          tests_bad;
  int unsigned assert_fails;

  mem_unit u_mem_unit (
    .clk    (clk),
    .rst    (rst),
    .ex_in  (ex_in),
    .wb_out (wb_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG);
    $display("timeout: tests still running after %0d time units", WATCHDOG);
    $display("Testbench failed");
    $finish;
  end

  function automatic logic [`MEM_DEPTH_LOG2-1:0] ref_index(input logic [`MEM_XLEN-1:0] addr);
    logic [`MEM_XLEN-1:0] off;
    off = addr - `MEM_BASE;
    return off[`MEM_DEPTH_LOG2+2:3];
  endfunction

  function automatic int ref_lane(input logic [`MEM_XLEN-1:0] addr);
    logic [`MEM_XLEN-1:0] off;
    off = addr - `MEM_BASE;
    return int'(off[2:0]);
  endfunction

  // expected writeback bundle, computed before the store of the same bundle lands
  function automatic mem_wb_t expected_wb(input ex_mem_t b);
    mem_wb_t              w;
    logic [`MEM_XLEN-1:0] dw;
    int                   sh;
    logic [7:0]           by;
    logic [15:0]          hw;
    logic [31:0]          wd;
    dw = ref_mem[ref_index(b.ex_data)];
    sh = ref_lane(b.ex_data);
    by = dw[sh*8 +: 8];
    hw = dw[(sh/2)*16 +: 16];
    wd = dw[(sh/4)*32 +: 32];
    case (b.op)
      MOP_LB:  w.result = {{56{by[7]}}, by};
      MOP_LBU: w.result = {56'd0, by};
      MOP_LH:  w.result = {{48{hw[15]}}, hw};
      MOP_LHU: w.result = {48'd0, hw};
      MOP_LW:  w.result = {{32{wd[31]}}, wd};
      MOP_LWU: w.result = {32'd0, wd};
      MOP_LD:  w.result = dw;
      default: w.result = b.ex_data;
    endcase
    w.rd_en   = b.rd_en;
    w.rd_addr = b.rd_addr;
    w.inst    = b.inst;
    w.pc      = b.pc;
    return w;
  endfunction

  task automatic ref_update(input ex_mem_t b);
    logic [`MEM_DEPTH_LOG2-1:0] idx;
    logic [`MEM_XLEN-1:0]       dw;
    int                         sh;
    idx = ref_index(b.ex_data);
    sh  = ref_lane(b.ex_data);
    dw  = ref_mem[idx];
    case (b.op)
      MOP_SB:  dw[sh*8 +: 8] = b.store_data[7:0];
      MOP_SH:  dw[(sh/2)*16 +: 16] = b.store_data[15:0];
      MOP_SW:  dw[(sh/4)*32 +: 32] = b.store_data[31:0];
      MOP_SD:  dw = b.store_data;
      default: ;
    endcase
    ref_mem[idx] = dw;
  endtask

  // sideband made unique per bundle
  function automatic ex_mem_t bundle(input mem_op_e op, input logic [`MEM_XLEN-1:0] addr,
                                     input logic [`MEM_XLEN-1:0] sdata);
    ex_mem_t b;
    b.op         = op;
    b.ex_data    = addr;
    b.store_data = sdata;
    b.rd_en      = 1'b1;
    b.rd_addr    = 5'(seq + 1);
    b.inst       = 32'h0000_0003 + 32'(seq << 7);
    b.pc         = 64'h0001_0000 + 64'(seq) * 4;
    return b;
  endfunction

  // called 10 units after an edge, returns 10 units after the next one
  task automatic send(input ex_mem_t b, output mem_wb_t exp);
    exp = expected_wb(b);
    ref_update(b);
    ex_in = b;
    seq++;
    @(posedge clk);
    #10;
  endtask

  task automatic check_wb(input mem_wb_t exp, input string what);
    checks++;
    if (wb_out !== exp) begin
      errors++;
      $display("Error at %0t: %s, wb_out %h expected %h", $time, what, wb_out, exp);
    end
  endtask

  task automatic check_result(input logic [`MEM_XLEN-1:0] exp, input string what);
    checks++;
    if (wb_out.result !== exp) begin
      errors++;
      $display("Error at %0t: %s, result %h expected %h", $time, what, wb_out.result, exp);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d mismatches", name, errors - errors_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    check_wb('0, "wb_out not cleared by reset");
    end_test("reset", e0);
  endtask

  task automatic test_passthrough();
    int      e0;
    ex_mem_t b;
    mem_wb_t exp;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      b = bundle(MOP_NONE, 64'hdead_beef_0000_0000 + 64'(i * 24), 64'h5555_0000 + 64'(i));
      b.rd_en = i[0];
      send(b, exp);
      check_wb(exp, $sformatf("pass-through bundle %0d", i));
    end
    end_test("pass-through", e0);
  endtask

  task automatic test_sd_ld();
    int                   e0;
    mem_wb_t              exp;
    logic [`MEM_XLEN-1:0] addrs [3];
    e0 = errors;
    // last one wraps onto the second doubleword
    addrs = '{`MEM_BASE + 64'h40, `MEM_BASE + 64'h1ff8, `MEM_BASE + 64'h2008};
    for (int k = 0; k < 3; k++) begin
      send(bundle(MOP_SD, addrs[k], 64'h0f1e_2d3c_4b5a_6978 ^ 64'(k * 32'h1111_1111)), exp);
      check_wb(exp, $sformatf("store doubleword %0d", k));
      send(bundle(MOP_LD, addrs[k], '0), exp);
      check_wb(exp, $sformatf("load doubleword %0d right after store", k));
    end
    end_test("store then load", e0);
  endtask

  task automatic test_store_merge();
    int                   e0;
    mem_wb_t              exp;
    mem_op_e              ops [3];
    int                   step [3];
    logic [`MEM_XLEN-1:0] addr;
    e0   = errors;
    ops  = '{MOP_SB, MOP_SH, MOP_SW};
    step = '{1, 2, 4};
    addr = `MEM_BASE + 64'h300;
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 8; off += step[s]) begin
        send(bundle(MOP_SD, addr, 64'h0123_4567_89ab_cdef), exp);
        check_wb(exp, "prefill doubleword");
        send(bundle(ops[s], addr + 64'(off), 64'hfedc_ba98_7654_3210 + 64'(off)), exp);
        check_wb(exp, $sformatf("%s at offset %0d", ops[s].name(), off));
        send(bundle(MOP_LD, addr, '0), exp);
        check_result(exp.result, $sformatf("merge of %s at offset %0d", ops[s].name(), off));
      end
    end
    end_test("partial stores", e0);
  endtask

  task automatic test_load_ext();
    int                   e0;
    mem_wb_t              exp;
    mem_op_e              ops [6];
    logic [`MEM_XLEN-1:0] addr;
    e0   = errors;
    ops  = '{MOP_LB, MOP_LBU, MOP_LH, MOP_LHU, MOP_LW, MOP_LWU};
    addr = `MEM_BASE + 64'h7f0;
    // every byte has its top bit set
    send(bundle(MOP_SD, addr, 64'h89ab_cdef_fedc_ba98), exp);
    check_wb(exp, "pattern store");
    for (int o = 0; o < 6; o++) begin
      for (int off = 0; off < 8; off++) begin
        send(bundle(ops[o], addr + 64'(off), '0), exp);
        check_result(exp.result, $sformatf("%s at offset %0d", ops[o].name(), off));
      end
    end
    end_test("load extension", e0);
  endtask

  task automatic test_random();
    int                   e0;
    int                   pick;
    logic [3:0]           opc;
    logic [31:0]          r;
    ex_mem_t              b;
    mem_wb_t              exp;
    logic [`MEM_XLEN-1:0] addrs [4];
    logic [`MEM_XLEN-1:0] a;
    e0    = errors;
    addrs = '{`MEM_BASE + 64'h18, `MEM_BASE + 64'h320, `MEM_BASE + 64'h1ff8,
              `MEM_BASE + 64'h2018};
    for (int k = 0; k < 4; k++) begin
      send(bundle(MOP_SD, addrs[k], {$random(seed), $random(seed)}), exp);
      check_wb(exp, $sformatf("random prefill %0d", k));
    end
    for (int n = 0; n < RAND_OPS; n++) begin
      pick = int'($unsigned($random(seed)) % 4);
      a    = addrs[pick] + 64'($unsigned($random(seed)) % 8);
      opc  = 4'($unsigned($random(seed)) % 12);
      b    = bundle(mem_op_e'(opc), a, {$random(seed), $random(seed)});
      r    = $random(seed);
      b.rd_en   = r[0];
      b.rd_addr = r[5:1];
      b.inst    = $random(seed);
      send(b, exp);
      check_wb(exp, $sformatf("random bundle %0d, %s", n, b.op.name()));
    end
    end_test("random mix", e0);
  endtask

  initial begin
    seed      = 17482;
    seq       = 0;
    errors    = 0;
    checks    = 0;
    tests_ok  = 0;
    tests_bad = 0;
    rst       = 1'b1;
    // sideband that reset must hide
    ex_in         = '0;
    ex_in.op      = MOP_NONE;
    ex_in.rd_en   = 1'b1;
    ex_in.rd_addr = 5'd7;
    ex_in.pc      = 64'h0000_0000_0000_0bad;
    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    rst = 1'b0;
    test_reset();
    test_passthrough();
    test_sd_ld();
    test_store_merge();
    test_load_ext();
    test_random();
    assert_fails = u_mem_unit.u_mem_unit_sva.reset_fails
                 + u_mem_unit.u_mem_unit_sva.follow_fails
                 + u_mem_unit.u_mem_unit_sva.unknown_fails;
    $display("tests ok %0d, tests failing %0d, checks %0d, mismatches %0d, assertion failures %0d",
             tests_ok, tests_bad, checks, errors, assert_fails);
    if (tests_bad == 0 && errors == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+design
design/mem_op_pkg.sv
design/pipe_pkg.sv
design/store_format.sv
design/data_ram.sv
design/load_format.sv
design/mem_unit.sv
bench/mem_unit_sva.sv
bench/mem_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mem_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f filelist.f --top-module mem_unit_tb \
  -o mem_unit_sim > build.log 2>&1 &&
  { ./obj_dir/mem_unit_sim +verilator+error+limit+1000 > sim.log 2>&1 || true; } &&
  cat sim.log &&
  grep -q "Testbench passed" sim.log &&
  echo "simulation run ok" ||
  { cat build.log; echo "simulation run failed"; exit 1; }
